// File: Bender.yml
package:
  name: pong

export_include_dirs:
  - include

sources:
  - logic/pong_pkg.sv
  - logic/sprite_plotter.sv
  - logic/pong_physics.sv
  - logic/pong_sequencer.sv
  - logic/pong_top.sv
  - target: test
    files:
      - test/pong_checker.sv
      - test/pong_tb.sv

// File: include/pong_config.svh
// field, sprite, start position, speed, colour and score defines
`ifndef PONG_CONFIG_SVH
`define PONG_CONFIG_SVH

`define PONG_FIELD_W     160
`define PONG_FIELD_H     120
`define PONG_X_BITS      8 // 0..159
`define PONG_Y_BITS      7 // 0..119
`define PONG_SPRITE      4 // ball and paddle are both 4x4

// top-left corner limits, sprite must stay on screen
`define PONG_X_MAX       (`PONG_FIELD_W - `PONG_SPRITE)
`define PONG_Y_MAX       (`PONG_FIELD_H - `PONG_SPRITE)

`define PONG_BALL_X0     78
`define PONG_BALL_Y0     58
`define PONG_BALL_DX0    (-2) // serve goes left and down
`define PONG_BALL_DY0    2

`define PONG_PAD_L_X     2
`define PONG_PAD_R_X     152
`define PONG_PAD_Y0      58
`define PONG_PAD_SLOW    1
`define PONG_PAD_FAST    2

`define PONG_WIN         11
`define PONG_SCORE_BITS  4
`define PONG_COLOUR_BITS 3 // one bit per rgb channel
`define PONG_PAD_COLOUR  {`PONG_COLOUR_BITS{1'b1}} // white
`define PONG_BG_COLOUR   {`PONG_COLOUR_BITS{1'b0}} // black

`endif

// File: logic/pong_physics.sv
// ball and paddle motion, wall and paddle bounce, scoring and position resets
`timescale 1ns/1ns
`include "pong_config.svh"

module pong_physics (
	input  logic                        clk,
	input  logic                        reset,
	input  pong_pkg::step_t             step_cmd_i,
	input  pong_pkg::obj_t              step_obj_i,
	input  pong_pkg::paddle_cmd_t       pad_l_i,
	input  pong_pkg::paddle_cmd_t       pad_r_i,
	output pong_pkg::pos_t              ball_o,
	output pong_pkg::pos_t              pad_l_o,
	output pong_pkg::pos_t              pad_r_o,
	output logic [`PONG_SCORE_BITS-1:0] score_l_o,
	output logic [`PONG_SCORE_BITS-1:0] score_r_o,
	output logic                        point_won_o
);
	localparam int XW     = `PONG_X_BITS;
	localparam int YW     = `PONG_Y_BITS;
	localparam int FACE_L = `PONG_PAD_L_X + `PONG_SPRITE; // column just right of left paddle
	localparam int FACE_R = `PONG_PAD_R_X - `PONG_SPRITE; // ball x touching right paddle

	pong_pkg::pos_t      ball_q;
	logic signed [XW:0]  dx_q;
	logic signed [YW:0]  dy_q;
	logic [YW-1:0]       pad_l_y_q, pad_r_y_q;

	logic                at_top, at_bot;
	logic signed [YW:0]  dy_eff;     // dy after any wall bounce
	logic [YW-1:0]       ball_ny;
	logic signed [XW:0]  ball_nx_s;  // unclamped
	logic [XW-1:0]       ball_nx;
	logic signed [XW:0]  dx_next;
	logic                near_l, near_r, hit_l, hit_r;
	logic                wall_l, wall_r;
	logic [YW-1:0]       pad_l_ny, pad_r_ny;
	logic                restart, clear_scores, move_ball;

	function automatic logic [YW-1:0] clamp_y(input logic signed [YW:0] v);
		logic [YW-1:0] r;
		if (v < 0)
			r = '0;
		else if (v > `PONG_Y_MAX)
			r = YW'(`PONG_Y_MAX);
		else
			r = v[YW-1:0];
		return r;
	endfunction

	// one paddle step, nothing without go
	function automatic logic [YW-1:0] pad_step(input logic [YW-1:0] y,
		input pong_pkg::paddle_cmd_t cmd);
		logic signed [YW:0] d;
		d = cmd.fast ? (YW+1)'(`PONG_PAD_FAST) : (YW+1)'(`PONG_PAD_SLOW);
		if (cmd.up)
			d = -d;
		if (!cmd.go)
			d = '0;
		return clamp_y($signed({1'b0, y}) + d);
	endfunction

	always_comb
	begin
		at_top  = ball_q.y == '0 && dy_q < 0;
		at_bot  = ball_q.y == YW'(`PONG_Y_MAX) && dy_q > 0;
		dy_eff  = (at_top || at_bot) ? -dy_q : dy_q; // flip before moving
		ball_ny = clamp_y($signed({1'b0, ball_q.y}) + dy_eff);

		wall_l    = ball_q.x == '0 && dx_q < 0;
		wall_r    = ball_q.x == XW'(`PONG_X_MAX) && dx_q > 0;
		ball_nx_s = $signed({1'b0, ball_q.x}) + dx_q;

		// rows overlap within sprite edge - 1
		near_l = (ball_q.y + (`PONG_SPRITE - 1) >= pad_l_y_q) &&
			(pad_l_y_q + (`PONG_SPRITE - 1) >= ball_q.y);
		near_r = (ball_q.y + (`PONG_SPRITE - 1) >= pad_r_y_q) &&
			(pad_r_y_q + (`PONG_SPRITE - 1) >= ball_q.y);
		hit_l  = dx_q < 0 && ball_q.x >= FACE_L && ball_nx_s <= FACE_L && near_l;
		hit_r  = dx_q > 0 && ball_q.x <= FACE_R && ball_nx_s >= FACE_R && near_r;

		if (hit_l)
			ball_nx = XW'(FACE_L); // snap onto face
		else if (hit_r)
			ball_nx = XW'(FACE_R);
		else if (ball_nx_s < 0)
			ball_nx = '0;
		else if (ball_nx_s > `PONG_X_MAX)
			ball_nx = XW'(`PONG_X_MAX);
		else
			ball_nx = ball_nx_s[XW-1:0];
		dx_next = (hit_l || hit_r) ? -dx_q : dx_q;

		pad_l_ny = pad_step(pad_l_y_q, pad_l_i);
		pad_r_ny = pad_step(pad_r_y_q, pad_r_i);
	end

	assign restart      = reset || step_cmd_i == pong_pkg::STEP_RESET_POINT ||
		step_cmd_i == pong_pkg::STEP_RESET_GAME;
	assign clear_scores = reset || step_cmd_i == pong_pkg::STEP_RESET_GAME;
	assign move_ball    = step_cmd_i == pong_pkg::STEP_MOVE && step_obj_i == pong_pkg::BALL;

	always_ff @(posedge clk)
	begin
		if (restart)
		begin
			ball_q    <= '{x: XW'(`PONG_BALL_X0), y: YW'(`PONG_BALL_Y0)};
			dx_q      <= (XW+1)'(`PONG_BALL_DX0);
			dy_q      <= (YW+1)'(`PONG_BALL_DY0);
			pad_l_y_q <= YW'(`PONG_PAD_Y0);
			pad_r_y_q <= YW'(`PONG_PAD_Y0);
		end
		else if (step_cmd_i == pong_pkg::STEP_MOVE)
		begin
			case (step_obj_i)
				pong_pkg::PAD_L: pad_l_y_q <= pad_l_ny;
				pong_pkg::PAD_R: pad_r_y_q <= pad_r_ny;
				default:
				begin
					if (!(wall_l || wall_r)) // ball parks on a side wall until reset
					begin
						ball_q <= '{x: ball_nx, y: ball_ny};
						dx_q   <= dx_next;
						dy_q   <= dy_eff;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (clear_scores)
		begin
			score_l_o <= '0;
			score_r_o <= '0;
		end
		else if (move_ball)
		begin
			if (wall_l)
				score_l_o <= score_l_o + 1'b1; // left wall counts for left, as on the board
			if (wall_r)
				score_r_o <= score_r_o + 1'b1;
		end
		point_won_o <= !reset && move_ball && (wall_l || wall_r);
	end

	assign ball_o  = ball_q;
	assign pad_l_o = '{x: XW'(`PONG_PAD_L_X), y: pad_l_y_q};
	assign pad_r_o = '{x: XW'(`PONG_PAD_R_X), y: pad_r_y_q};

	a_on_field: assert property (@(posedge clk) disable iff (reset)
		step_cmd_i != pong_pkg::STEP_NONE |=> ball_q.x <= `PONG_X_MAX &&
		ball_q.y <= `PONG_Y_MAX && pad_l_y_q <= `PONG_Y_MAX && pad_r_y_q <= `PONG_Y_MAX);

endmodule

// File: logic/pong_pkg.sv
// shared structs and enums for positions, pixels, paddle controls and game sequencing
`include "pong_config.svh"

package pong_pkg;

	// top-left corner of a sprite
	typedef struct packed {
		logic [`PONG_X_BITS-1:0] x;
		logic [`PONG_Y_BITS-1:0] y;
	} pos_t;

	// one framebuffer write
	typedef struct packed {
		logic [`PONG_X_BITS-1:0]      x;
		logic [`PONG_Y_BITS-1:0]      y;
		logic [`PONG_COLOUR_BITS-1:0] colour;
	} pixel_t;

	// player controls
	typedef struct packed {
		logic go;   // move this step
		logic up;   // toward row 0
		logic fast; // double step
	} paddle_cmd_t;

	typedef enum logic [1:0] {
		BALL,
		PAD_L,
		PAD_R
	} obj_t;

	typedef enum logic [1:0] {
		STEP_NONE,
		STEP_MOVE,
		STEP_RESET_POINT, // positions and serve velocity
		STEP_RESET_GAME   // same, plus scores
	} step_t;

	typedef enum logic [3:0] {
		SEQ_START,
		SEQ_SERVE,   // wait for serve release
		SEQ_WAIT,    // frame tick countdown
		SEQ_ERASE,
		SEQ_STEP,
		SEQ_DRAW,
		SEQ_CLEAR,   // wipe all sprites after a point
		SEQ_POINT,
		SEQ_OVER,
		SEQ_NEWGAME
	} seq_state_t;

endpackage

// File: logic/pong_sequencer.sv
// game FSM, frame tick counter, serve edge detect and erase/step/draw ordering
`timescale 1ns/1ns
`include "pong_config.svh"

module pong_sequencer #(
	parameter int tick_cycles = 200
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        serve_i,
	input  logic                        new_game_i,
	input  logic                        point_won_i,
	input  logic [`PONG_SCORE_BITS-1:0] score_l_i,
	input  logic [`PONG_SCORE_BITS-1:0] score_r_i,
	input  logic                        draw_done_i,
	output logic                        draw_start_o,
	output pong_pkg::obj_t              draw_obj_o,
	output logic                        draw_erase_o,
	output pong_pkg::step_t             step_cmd_o,
	output pong_pkg::obj_t              step_obj_o,
	output logic                        serving_o,
	output logic                        game_over_o
);
	localparam int TICK_W = $clog2(tick_cycles + 1);

	pong_pkg::seq_state_t state_q, state_d;
	pong_pkg::obj_t       obj_q, obj_d;
	logic [TICK_W-1:0]    tick_q;
	logic                 launch;    // draw_start on next cycle
	logic                 serve_q, serve_rel;
	logic                 point_q;   // ball left the field this frame
	logic                 won;

	assign serve_rel = serve_q && !serve_i; // high then low
	assign won       = score_l_i >= `PONG_WIN || score_r_i >= `PONG_WIN;

	always_comb
	begin
		state_d = state_q;
		obj_d   = obj_q;
		launch  = 1'b0;
		case (state_q)
			pong_pkg::SEQ_START: state_d = pong_pkg::SEQ_SERVE;
			pong_pkg::SEQ_SERVE:
				if (serve_rel)
					state_d = pong_pkg::SEQ_WAIT;
			pong_pkg::SEQ_WAIT:
				if (tick_q == '0) // frame tick
				begin
					state_d = pong_pkg::SEQ_ERASE;
					obj_d   = pong_pkg::BALL;
					launch  = 1'b1;
				end
			pong_pkg::SEQ_ERASE:
				if (draw_done_i)
					state_d = pong_pkg::SEQ_STEP;
			pong_pkg::SEQ_STEP:
			begin
				state_d = pong_pkg::SEQ_DRAW;
				launch  = 1'b1;
			end
			pong_pkg::SEQ_DRAW:
				if (draw_done_i)
				begin
					launch = obj_q != pong_pkg::PAD_R;
					if (obj_q == pong_pkg::PAD_R)
						state_d = pong_pkg::SEQ_WAIT; // frame done
					else if (obj_q == pong_pkg::BALL && point_q)
						state_d = pong_pkg::SEQ_CLEAR; // start wiping at the ball
					else
					begin
						state_d = pong_pkg::SEQ_ERASE;
						obj_d   = (obj_q == pong_pkg::BALL) ? pong_pkg::PAD_L : pong_pkg::PAD_R;
					end
				end
			pong_pkg::SEQ_CLEAR:
				if (draw_done_i)
				begin
					if (obj_q == pong_pkg::PAD_R)
						state_d = pong_pkg::SEQ_POINT;
					else
					begin
						obj_d  = (obj_q == pong_pkg::BALL) ? pong_pkg::PAD_L : pong_pkg::PAD_R;
						launch = 1'b1;
					end
				end
			pong_pkg::SEQ_POINT: state_d = won ? pong_pkg::SEQ_OVER : pong_pkg::SEQ_SERVE;
			pong_pkg::SEQ_OVER:
				if (new_game_i)
					state_d = pong_pkg::SEQ_NEWGAME;
			pong_pkg::SEQ_NEWGAME: state_d = pong_pkg::SEQ_SERVE;
			default: state_d = pong_pkg::SEQ_START;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q      <= pong_pkg::SEQ_START;
			obj_q        <= pong_pkg::BALL;
			tick_q       <= '0;
			serve_q      <= 1'b0;
			point_q      <= 1'b0;
			draw_start_o <= 1'b0;
		end
		else
		begin
			state_q      <= state_d;
			obj_q        <= obj_d;
			serve_q      <= serve_i;
			draw_start_o <= launch;
			if (state_d == pong_pkg::SEQ_WAIT && state_q != pong_pkg::SEQ_WAIT)
				tick_q <= TICK_W'(tick_cycles - 1); // counted from frame end
			else if (state_q == pong_pkg::SEQ_WAIT && tick_q != '0)
				tick_q <= tick_q - 1'b1;
			if (point_won_i)
				point_q <= 1'b1;
			else if (state_q == pong_pkg::SEQ_POINT)
				point_q <= 1'b0;
		end
	end

	always_comb
	begin
		case (state_q)
			pong_pkg::SEQ_STEP:    step_cmd_o = pong_pkg::STEP_MOVE;
			pong_pkg::SEQ_POINT:   step_cmd_o = pong_pkg::STEP_RESET_POINT;
			pong_pkg::SEQ_NEWGAME: step_cmd_o = pong_pkg::STEP_RESET_GAME;
			default:               step_cmd_o = pong_pkg::STEP_NONE;
		endcase
	end

	assign step_obj_o   = obj_q;
	assign draw_obj_o   = obj_q;
	assign draw_erase_o = state_q == pong_pkg::SEQ_ERASE || state_q == pong_pkg::SEQ_CLEAR;
	assign serving_o    = state_q == pong_pkg::SEQ_SERVE;
	assign game_over_o  = state_q == pong_pkg::SEQ_OVER;

	// plotter handshake, one sprite in flight at a time
	a_start_after_done: assert property (@(posedge clk) disable iff (reset)
		draw_start_o |=> !draw_start_o until_with draw_done_i);
	a_no_step_in_draw: assert property (@(posedge clk) disable iff (reset)
		draw_start_o |-> (step_cmd_o == pong_pkg::STEP_NONE) until_with draw_done_i);

endmodule

// File: logic/pong_top.sv
// paddle game top level, sequencer and physics feeding one sprite plotter
`timescale 1ns/1ns
`include "pong_config.svh"

module pong_top #(
	parameter int tick_cycles = 200
) (
	input  logic                         clk,
	input  logic                         reset,
	input  pong_pkg::paddle_cmd_t        pad_l_i,
	input  pong_pkg::paddle_cmd_t        pad_r_i,
	input  logic                         serve_i,
	input  logic                         new_game_i,
	input  logic [`PONG_COLOUR_BITS-1:0] ball_colour_i,
	output pong_pkg::pixel_t             pixel_o,
	output logic                         pixel_valid_o,
	input  logic                         pixel_ready_i,
	output logic [`PONG_SCORE_BITS-1:0]  score_l_o,
	output logic [`PONG_SCORE_BITS-1:0]  score_r_o,
	output logic                         serving_o,
	output logic                         game_over_o
);
	logic            draw_start, draw_erase, draw_done, point_won;
	pong_pkg::obj_t  draw_obj, step_obj;
	pong_pkg::step_t step_cmd;
	pong_pkg::pos_t  ball, pad_l, pad_r; // current sprite corners

	pong_sequencer #(.tick_cycles(tick_cycles)) pong_sequencer_i (
		.clk, .reset, .serve_i, .new_game_i,
		.point_won_i(point_won), .score_l_i(score_l_o), .score_r_i(score_r_o),
		.draw_done_i(draw_done), .draw_start_o(draw_start), .draw_obj_o(draw_obj),
		.draw_erase_o(draw_erase), .step_cmd_o(step_cmd), .step_obj_o(step_obj),
		.serving_o, .game_over_o);

	pong_physics pong_physics_i (
		.clk, .reset, .step_cmd_i(step_cmd), .step_obj_i(step_obj), .pad_l_i, .pad_r_i,
		.ball_o(ball), .pad_l_o(pad_l), .pad_r_o(pad_r),
		.score_l_o, .score_r_o, .point_won_o(point_won));

	sprite_plotter sprite_plotter_i (
		.clk, .reset, .draw_start_i(draw_start), .draw_obj_i(draw_obj),
		.draw_erase_i(draw_erase), .ball_i(ball), .pad_l_i(pad_l), .pad_r_i(pad_r),
		.ball_colour_i, .pixel_o, .pixel_valid_o, .pixel_ready_i,
		.draw_done_o(draw_done));

endmodule

// File: logic/sprite_plotter.sv
// 4x4 sprite walker emitting raster-order pixels over a valid/ready stream
`timescale 1ns/1ns
`include "pong_config.svh"

module sprite_plotter (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         draw_start_i,
	input  pong_pkg::obj_t               draw_obj_i,
	input  logic                         draw_erase_i,
	input  pong_pkg::pos_t               ball_i,
	input  pong_pkg::pos_t               pad_l_i,
	input  pong_pkg::pos_t               pad_r_i,
	input  logic [`PONG_COLOUR_BITS-1:0] ball_colour_i,
	output pong_pkg::pixel_t             pixel_o,
	output logic                         pixel_valid_o,
	input  logic                         pixel_ready_i,
	output logic                         draw_done_o
);
	localparam int SUB_W = $clog2(`PONG_SPRITE); // offset bits per axis
	localparam int CNT_W = 2 * SUB_W;

	pong_pkg::pos_t               origin_d, origin_q;
	logic [`PONG_COLOUR_BITS-1:0] colour_d, colour_q;
	logic [CNT_W-1:0]             cnt_q; // pixel index, x in low bits
	logic                         busy_q;
	logic                         start, xfer, last;

	assign start = draw_start_i && !busy_q;
	assign xfer  = busy_q && pixel_ready_i;
	assign last  = cnt_q == CNT_W'(`PONG_SPRITE * `PONG_SPRITE - 1);

	// origin and colour picked at start
	always_comb
	begin
		case (draw_obj_i)
			pong_pkg::PAD_L: origin_d = pad_l_i;
			pong_pkg::PAD_R: origin_d = pad_r_i;
			default:         origin_d = ball_i;
		endcase
		if (draw_erase_i)
			colour_d = `PONG_BG_COLOUR;
		else if (draw_obj_i == pong_pkg::BALL)
			colour_d = ball_colour_i;
		else
			colour_d = `PONG_PAD_COLOUR;
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			origin_q <= origin_d;
			colour_q <= colour_d;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy_q      <= 1'b0;
			cnt_q       <= '0;
			draw_done_o <= 1'b0;
		end
		else
		begin
			draw_done_o <= 1'b0; // single cycle pulse
			if (start)
			begin
				busy_q <= 1'b1;
				cnt_q  <= '0;
			end
			else if (xfer)
			begin
				cnt_q <= cnt_q + 1'b1; // wraps back to 0 after pixel 15
				if (last)
				begin
					busy_q      <= 1'b0;
					draw_done_o <= 1'b1;
				end
			end
		end
	end

	// output comes straight from registers, so it cannot move while stalled
	always_comb
	begin
		pixel_o.x      = origin_q.x + `PONG_X_BITS'(cnt_q[SUB_W-1:0]);
		pixel_o.y      = origin_q.y + `PONG_Y_BITS'(cnt_q[CNT_W-1:SUB_W]);
		pixel_o.colour = colour_q;
	end
	assign pixel_valid_o = busy_q;

	a_stall_hold: assert property (@(posedge clk) disable iff (reset)
		pixel_valid_o && !pixel_ready_i |=> pixel_valid_o && $stable(pixel_o));

endmodule

// File: tb.f
+incdir+include
logic/pong_pkg.sv
logic/sprite_plotter.sv
logic/pong_physics.sv
logic/pong_sequencer.sv
logic/pong_top.sv
test/pong_checker.sv
test/pong_tb.sv

// File: test/pong_checker.sv
// pixel stream scoreboard, score and flag port checks, row and total reporting
`timescale 1ns/1ns
`include "pong_config.svh"

module pong_checker (
	input  logic                        clk,
	input  logic                        reset,
	input  pong_pkg::pixel_t            pixel_i,
	input  logic                        pixel_valid_i,
	input  logic                        pixel_ready_i,
	input  logic [`PONG_SCORE_BITS-1:0] score_l_i,
	input  logic [`PONG_SCORE_BITS-1:0] score_r_i,
	input  logic                        serving_i,
	input  logic                        game_over_i
);
	pong_pkg::pixel_t exp_q[$]; // pixels still owed by the DUT, in order
	pong_pkg::pixel_t want;
	int               err_cnt = 0;
	int               row_err_base = 0; // errors before the current row
	int               pix_cnt = 0;
	int               row_cnt = 0;

	function automatic void push_pixel(input pong_pkg::pixel_t p);
		exp_q.push_back(p);
	endfunction

	function automatic int pending();
		return exp_q.size();
	endfunction

	function automatic int error_count();
		return err_cnt;
	endfunction

	task automatic compare_value(input string name, input int exp, input int act);
		if (exp != act)
		begin
			$display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
			err_cnt++;
		end
	endtask

	// failures found elsewhere, e.g. a wait that ran out
	task automatic count_failure();
		err_cnt++;
	endtask

	// called between frames, plotter idle
	task automatic check_ports(input int exp_l, input int exp_r, input logic exp_serving,
		input logic exp_over);
		compare_value("score_l_o", exp_l, score_l_i);
		compare_value("score_r_o", exp_r, score_r_i);
		compare_value("serving_o", exp_serving, serving_i);
		compare_value("game_over_o", exp_over, game_over_i);
		compare_value("pixel_valid_o", 0, pixel_valid_i); // no sprite in flight
	endtask

	task automatic report_row(input int idx);
		if (err_cnt == row_err_base)
			$display("row %0d ok", idx);
		else
			$display("row %0d failed with %0d errors", idx, err_cnt - row_err_base);
		row_err_base = err_cnt;
		row_cnt++;
	endtask

	task automatic report_totals();
		$display("rows %0d, pixels checked %0d, errors %0d", row_cnt, pix_cnt, err_cnt);
	endtask

	// one compare per transfer, pre-edge values
	always @(posedge clk)
	begin
		if (!reset && pixel_valid_i && pixel_ready_i)
		begin
			pix_cnt++;
			if (exp_q.size() == 0)
			begin
				$display("unexpected pixel at %0t: x %0d y %0d colour %0d while none was due",
					$time, pixel_i.x, pixel_i.y, pixel_i.colour);
				err_cnt++;
			end
			else
			begin
				want = exp_q.pop_front();
				compare_value("pixel_o.x", want.x, pixel_i.x);
				compare_value("pixel_o.y", want.y, pixel_i.y);
				compare_value("pixel_o.colour", want.colour, pixel_i.colour);
			end
		end
	end

endmodule

// File: test/pong_tb.sv
// testbench top with clock, reset, ready LCG, stimulus table loop, DUT and frame-level game model
`timescale 1ns/1ns
`include "pong_config.svh"

module pong_tb;
	localparam int FRAME_TIMEOUT = 3000; // cycles for tick plus stalled pixels
	localparam int FLAG_TIMEOUT  = 100;
	localparam int IDLE_CYCLES   = 600;  // quiet window longer than one tick
	localparam int N_ROWS        = 12;
	localparam int FACE_L        = `PONG_PAD_L_X + `PONG_SPRITE; // ball x on left face
	localparam int FACE_R        = `PONG_PAD_R_X - `PONG_SPRITE;
	localparam logic [`PONG_COLOUR_BITS-1:0] BALL_COLOUR = 3'b100;

	// {go, up, fast}
	localparam pong_pkg::paddle_cmd_t PAD_IDLE    = 3'b000;
	localparam pong_pkg::paddle_cmd_t PAD_DN_SLOW = 3'b100;
	localparam pong_pkg::paddle_cmd_t PAD_DN_FAST = 3'b101;
	localparam pong_pkg::paddle_cmd_t PAD_UP_SLOW = 3'b110;
	localparam pong_pkg::paddle_cmd_t PAD_UP_FAST = 3'b111;

	typedef struct packed {
		pong_pkg::paddle_cmd_t       pad_l;
		pong_pkg::paddle_cmd_t       pad_r;
		logic                        serve;      // serve before each rep
		logic                        new_game;
		logic [7:0]                  frames;     // upper bound as a point ends the rep
		logic [3:0]                  reps;
		logic                        rand_ready;
		logic [`PONG_SCORE_BITS-1:0] score_l;    // expected at row end
		logic [`PONG_SCORE_BITS-1:0] score_r;
		logic                        serving;
		logic                        over;
	} row_t;

	logic                         clk;
	logic                         reset;
	pong_pkg::paddle_cmd_t        pad_l, pad_r;
	logic                         serve, new_game;
	logic [`PONG_COLOUR_BITS-1:0] ball_colour;
	pong_pkg::pixel_t             pixel;
	logic                         pixel_valid, pixel_ready;
	logic [`PONG_SCORE_BITS-1:0]  score_l, score_r;
	logic                         serving, game_over;

	row_t        rows [N_ROWS];
	row_t        cur;        // row being applied with the paddles the model reads
	logic [31:0] lcg_state;
	logic        rand_ready;
	bit          timed_out;
	int          bx, by, bdx, bdy, ply, pry, sl, sr; // model state
	bit          m_serving, m_over;

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	always @(posedge clk)
	begin
		lcg_state = lcg_next(lcg_state);
		pixel_ready <= rand_ready ? lcg_state[16] : 1'b1; // mid bit since low bits cycle short
	end

	pong_top #(.tick_cycles(200)) pong_top_i (
		.clk, .reset, .pad_l_i(pad_l), .pad_r_i(pad_r), .serve_i(serve),
		.new_game_i(new_game), .ball_colour_i(ball_colour), .pixel_o(pixel),
		.pixel_valid_o(pixel_valid), .pixel_ready_i(pixel_ready), .score_l_o(score_l),
		.score_r_o(score_r), .serving_o(serving), .game_over_o(game_over));

	pong_checker pong_checker_i (
		.clk, .reset, .pixel_i(pixel), .pixel_valid_i(pixel_valid), .pixel_ready_i(pixel_ready),
		.score_l_i(score_l), .score_r_i(score_r), .serving_i(serving), .game_over_i(game_over));

	function automatic row_t make_row(input pong_pkg::paddle_cmd_t l, input pong_pkg::paddle_cmd_t r,
		input logic sv, input logic ng, input int frames, input int reps, input logic rnd,
		input int exp_l, input int exp_r, input logic exp_sv, input logic exp_ov);
		row_t t;
		t.pad_l      = l;
		t.pad_r      = r;
		t.serve      = sv;
		t.new_game   = ng;
		t.frames     = 8'(frames);
		t.reps       = 4'(reps);
		t.rand_ready = rnd;
		t.score_l    = `PONG_SCORE_BITS'(exp_l);
		t.score_r    = `PONG_SCORE_BITS'(exp_r);
		t.serving    = exp_sv;
		t.over       = exp_ov;
		return t;
	endfunction

	function automatic int clamp(input int v, input int hi);
		return (v < 0) ? 0 : ((v > hi) ? hi : v);
	endfunction

	function automatic int pad_move(input int y, input pong_pkg::paddle_cmd_t c);
		int s;
		s = c.fast ? `PONG_PAD_FAST : `PONG_PAD_SLOW;
		if (c.up)
			s = -s; // up is toward row 0
		return c.go ? clamp(y + s, `PONG_Y_MAX) : y;
	endfunction

	task automatic model_restart(input bit clear_scores);
		bx  = `PONG_BALL_X0;
		by  = `PONG_BALL_Y0;
		bdx = `PONG_BALL_DX0;
		bdy = `PONG_BALL_DY0;
		ply = `PONG_PAD_Y0;
		pry = `PONG_PAD_Y0;
		if (clear_scores)
		begin
			sl = 0;
			sr = 0;
		end
	endtask

	// one ball step that sets point when it sits on a side wall
	task automatic model_ball(output bit point);
		int nx, ny, dy;
		point = 1'b0;
		if ((bx == 0 && bdx < 0) || (bx == `PONG_X_MAX && bdx > 0))
		begin
			point = 1'b1; // ball stays put
			if (bx == 0)
				sl++;
			else
				sr++;
		end
		else
		begin
			dy = bdy;
			if ((by == 0 && dy < 0) || (by == `PONG_Y_MAX && dy > 0))
				dy = -dy; // wall bounce first
			ny = clamp(by + dy, `PONG_Y_MAX);
			nx = bx + bdx;
			if (bdx < 0 && bx >= FACE_L && nx <= FACE_L &&
				(by > ply ? by - ply : ply - by) <= `PONG_SPRITE - 1)
			begin
				nx  = FACE_L;
				bdx = -bdx;
			end
			else if (bdx > 0 && bx <= FACE_R && nx >= FACE_R &&
				(by > pry ? by - pry : pry - by) <= `PONG_SPRITE - 1)
			begin
				nx  = FACE_R;
				bdx = -bdx;
			end
			else
				nx = clamp(nx, `PONG_X_MAX);
			bx  = nx;
			by  = ny;
			bdy = dy;
		end
	endtask

	task automatic push_sprite(input int ox, input int oy, input logic [`PONG_COLOUR_BITS-1:0] c);
		pong_pkg::pixel_t p;
		for (int r = 0; r < `PONG_SPRITE; r++)
			for (int col = 0; col < `PONG_SPRITE; col++) // x fastest
			begin
				p.x      = `PONG_X_BITS'(ox + col);
				p.y      = `PONG_Y_BITS'(oy + r);
				p.colour = c;
				pong_checker_i.push_pixel(p);
			end
	endtask

	// queue expected pixels of one frame and advance the model
	task automatic model_frame(output bit point);
		push_sprite(bx, by, `PONG_BG_COLOUR);
		model_ball(point);
		push_sprite(bx, by, BALL_COLOUR);
		if (point)
		begin
			push_sprite(bx, by, `PONG_BG_COLOUR); // wipe everything
			push_sprite(`PONG_PAD_L_X, ply, `PONG_BG_COLOUR);
			push_sprite(`PONG_PAD_R_X, pry, `PONG_BG_COLOUR);
			model_restart(1'b0);
		end
		else
		begin
			push_sprite(`PONG_PAD_L_X, ply, `PONG_BG_COLOUR);
			ply = pad_move(ply, cur.pad_l);
			push_sprite(`PONG_PAD_L_X, ply, `PONG_PAD_COLOUR);
			push_sprite(`PONG_PAD_R_X, pry, `PONG_BG_COLOUR);
			pry = pad_move(pry, cur.pad_r);
			push_sprite(`PONG_PAD_R_X, pry, `PONG_PAD_COLOUR);
		end
	endtask

	task automatic fail_timeout();
		timed_out = 1'b1;
		pong_checker_i.count_failure();
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		@(negedge clk);
		while (pong_checker_i.pending() != 0 && n < FRAME_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (pong_checker_i.pending() != 0)
		begin
			$display("timeout: no frame completed within %0d cycles", FRAME_TIMEOUT);
			fail_timeout();
		end
	endtask

	task automatic wait_flag(input bit want_over);
		int n;
		n = 0;
		@(negedge clk);
		while ((want_over ? game_over : serving) !== 1'b1 && n < FLAG_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if ((want_over ? game_over : serving) !== 1'b1)
		begin
			if (want_over)
				$display("timeout: game_over_o never went high");
			else
				$display("timeout: serving_o never went high");
			fail_timeout();
		end
	endtask

	task automatic serve_ball();
		wait_flag(1'b0);
		@(posedge clk);
		serve <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		serve <= 1'b0; // release starts play
		m_serving = 1'b0;
	endtask

	task automatic run_frame(output bit point);
		model_frame(point);
		wait_drained();
		if (point && !timed_out)
		begin
			m_over    = sl >= `PONG_WIN || sr >= `PONG_WIN;
			m_serving = !m_over;
			wait_flag(m_over);
		end
		if (!timed_out)
			pong_checker_i.check_ports(sl, sr, m_serving, m_over);
	endtask

	task automatic apply_row(input int idx);
		bit point;
		cur = rows[idx];
		@(posedge clk);
		pad_l      <= cur.pad_l;
		pad_r      <= cur.pad_r;
		rand_ready <= cur.rand_ready;
		if (cur.new_game)
		begin
			wait_flag(1'b1);
			@(posedge clk);
			new_game <= 1'b1;
			@(posedge clk);
			new_game <= 1'b0;
			model_restart(1'b1);
			m_over    = 1'b0;
			m_serving = 1'b1;
			wait_flag(1'b0);
		end
		for (int rep = 0; rep < cur.reps && !timed_out; rep++)
		begin
			if (cur.serve)
				serve_ball();
			point = 1'b0;
			for (int f = 0; f < cur.frames && !point && !timed_out; f++)
				run_frame(point);
		end
		if (cur.frames == 0)
			repeat (IDLE_CYCLES) @(posedge clk); // any pixel here is flagged
		@(negedge clk);
		pong_checker_i.check_ports(cur.score_l, cur.score_r, cur.serving, cur.over);
		pong_checker_i.report_row(idx);
	endtask

	initial
	begin
		reset       = 1'b1;
		serve       = 1'b0;
		new_game    = 1'b0;
		pad_l       = PAD_IDLE;
		pad_r       = PAD_IDLE;
		ball_colour = BALL_COLOUR;
		pixel_ready = 1'b1;
		rand_ready  = 1'b0;
		lcg_state   = 32'd93296;
		timed_out   = 1'b0;
		m_serving   = 1'b1;
		m_over      = 1'b0;
		model_restart(1'b1);
		// pad_l, pad_r, serve, new game, frames, reps, random ready, score l, r, serving, over
		rows[0]  = make_row(PAD_IDLE, PAD_IDLE, 0, 0, 0, 1, 0, 0, 0, 1, 0);   // quiet after reset
		rows[1]  = make_row(PAD_IDLE, PAD_IDLE, 1, 0, 10, 1, 0, 0, 0, 0, 0);  // free flight
		rows[2]  = make_row(PAD_DN_FAST, PAD_UP_FAST, 0, 0, 20, 1, 0, 0, 0, 0, 0);
		rows[3]  = make_row(PAD_DN_SLOW, PAD_UP_SLOW, 0, 0, 5, 1, 0, 0, 0, 0, 0);
		rows[4]  = make_row(PAD_DN_FAST, PAD_UP_FAST, 0, 0, 10, 1, 0, 0, 0, 0, 0); // hit and pinned
		rows[5]  = make_row(PAD_IDLE, PAD_IDLE, 0, 0, 80, 1, 0, 0, 1, 1, 0);  // top wall then right miss
		rows[6]  = make_row(PAD_IDLE, PAD_IDLE, 0, 0, 0, 1, 0, 0, 1, 1, 0);   // held until next serve
		rows[7]  = make_row(PAD_IDLE, PAD_IDLE, 1, 0, 50, 1, 1, 1, 1, 1, 0);  // back-pressure
		rows[8]  = make_row(PAD_IDLE, PAD_IDLE, 1, 0, 50, 10, 0, 11, 1, 0, 1); // run to 11
		rows[9]  = make_row(PAD_IDLE, PAD_IDLE, 0, 0, 0, 1, 0, 11, 1, 0, 1);  // frozen in over
		rows[10] = make_row(PAD_IDLE, PAD_IDLE, 0, 1, 0, 1, 0, 0, 0, 1, 0);
		rows[11] = make_row(PAD_IDLE, PAD_IDLE, 1, 0, 5, 1, 1, 0, 0, 0, 0);
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < N_ROWS && !timed_out; i++)
			apply_row(i);
		pong_checker_i.report_totals();
		if (pong_checker_i.error_count() == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
